// ==== design/fpAdder_defs.svh ====
// Field widths, exponent bias and normalization shift bound of the single-precision adder
`ifndef FP_ADDER_DEFS_SVH
`define FP_ADDER_DEFS_SVH

// IEEE-754 single precision fields
`define FP_EXP_BITS 8
`define FP_MAN_BITS 23

// Hidden bit, fraction and eight low guard positions
`define FP_EXT_BITS 32

`define FP_BIAS 127

// Upper bound on left shifts during normalization
`define FP_MAX_NORM_SHIFTS 31

`endif

// ==== design/fpAdderPkg.sv ====
// Operand class and controller state types of the floating-point adder
package fpAdderPkg;

    // Operand kind after field decode
    typedef enum logic [2:0]
    {
        fpZero,
        fpSubnormal,
        fpNormal,
        fpInfinity,
        fpNan
    } fpClass;

    // Sequencing states of the add controller
    typedef enum logic [2:0]
    {
        stateIdle,
        stateAlign,
        stateAdd,
        stateNormRight,
        stateNormLeft,
        stateRound,
        stateFinish
    } addState;

endpackage

// ==== design/fpUnpack.sv ====
// Operand registers, field split and classification of both operands
`timescale 1ns/1ps
`include "fpAdder_defs.svh"

module fpUnpack
    import fpAdderPkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    load,
    input  logic [31:0]             operandA,
    input  logic [31:0]             operandB,
    input  logic                    subtract,
    output logic                    signA,
    output logic                    signB,
    output logic [`FP_EXP_BITS-1:0] exponentA,
    output logic [`FP_EXP_BITS-1:0] exponentB,
    output logic [`FP_MAN_BITS-1:0] mantissaA,
    output logic [`FP_MAN_BITS-1:0] mantissaB,
    output fpClass                  classA,
    output fpClass                  classB
);

    logic [31:0] regA;
    logic [31:0] regB;
    logic        regSubtract;

    function automatic fpClass classify(input logic [31:0] value);
        logic [`FP_EXP_BITS-1:0] field;
        logic                    fractionZero;
        field = value[30 -: `FP_EXP_BITS];
        fractionZero = (value[`FP_MAN_BITS-1:0] == '0);
        if (field == '0)
            return fractionZero ? fpZero : fpSubnormal;
        else if (field == '1)
            return fractionZero ? fpInfinity : fpNan;
        return fpNormal;
    endfunction

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            regA <= '0;
            regB <= '0;
            regSubtract <= 1'b0;
        end
        else if (load)
        begin
            regA <= operandA;
            regB <= operandB;
            regSubtract <= subtract;
        end
    end

    assign classA = classify(regA);
    assign classB = classify(regB);
    assign signA = regA[31];
    // Subtraction is addition with B negated
    assign signB = regB[31] ^ regSubtract;
    assign mantissaA = regA[`FP_MAN_BITS-1:0];
    assign mantissaB = regB[`FP_MAN_BITS-1:0];

    // Subnormals sit at an effective exponent of one
    assign exponentA = (classA == fpSubnormal) ? `FP_EXP_BITS'd1 : regA[30 -: `FP_EXP_BITS];
    assign exponentB = (classB == fpSubnormal) ? `FP_EXP_BITS'd1 : regB[30 -: `FP_EXP_BITS];

endmodule

// ==== design/fpAlign.sv ====
// Exponent comparison, mantissa alignment, sticky and bypass decision
`timescale 1ns/1ps
`include "fpAdder_defs.svh"

module fpAlign
    import fpAdderPkg::*;
(
    input  logic [`FP_EXP_BITS-1:0] exponentA,
    input  logic [`FP_EXP_BITS-1:0] exponentB,
    input  logic [`FP_MAN_BITS-1:0] mantissaA,
    input  logic [`FP_MAN_BITS-1:0] mantissaB,
    input  fpClass                  classA,
    input  fpClass                  classB,
    output logic [`FP_EXP_BITS-1:0] exponentOut,
    output logic [`FP_EXT_BITS-1:0] alignedMantissaA,
    output logic [`FP_EXT_BITS-1:0] alignedMantissaB,
    output logic                    sticky,
    output logic                    shiftOverflow,
    output logic                    bypass
);

    localparam int GuardBits = `FP_EXT_BITS - `FP_MAN_BITS - 1;

    logic                    bLarger;
    logic [`FP_EXP_BITS-1:0] exponentDiff;
    logic [`FP_EXT_BITS-1:0] extendedA;
    logic [`FP_EXT_BITS-1:0] extendedB;
    logic [`FP_EXT_BITS-1:0] smallExtended;
    logic [`FP_EXT_BITS-1:0] smallShifted;

    // Hidden bit only for normal operands
    assign extendedA = {classA == fpNormal, mantissaA, {GuardBits{1'b0}}};
    assign extendedB = {classB == fpNormal, mantissaB, {GuardBits{1'b0}}};

    assign bLarger = (exponentB > exponentA);

    always_comb
    begin
        if (bLarger)
        begin
            exponentOut = exponentB;
            exponentDiff = exponentB - exponentA;
            smallExtended = extendedA;
        end
        else
        begin
            exponentOut = exponentA;
            exponentDiff = exponentA - exponentB;
            smallExtended = extendedB;
        end
    end

    // Equal exponents shift by zero
    assign smallShifted = smallExtended >> exponentDiff;

    assign alignedMantissaA = bLarger ? smallShifted : extendedA;
    assign alignedMantissaB = bLarger ? extendedB : smallShifted;

    // Any set bit below the shift amount falls out of the window
    assign shiftOverflow = ((smallShifted << exponentDiff) != smallExtended);

    // Lost bits only ever reach rounding as sticky
    assign sticky = shiftOverflow;

    assign bypass = (classA == fpZero) || (classA == fpInfinity) || (classA == fpNan) ||
                    (classB == fpZero) || (classB == fpInfinity) || (classB == fpNan);

endmodule

// ==== design/fpMantissaAdd.sv ====
// Signed add or subtract of aligned mantissas and special-result selection
`timescale 1ns/1ps
`include "fpAdder_defs.svh"

module fpMantissaAdd
    import fpAdderPkg::*;
(
    input  logic [`FP_EXT_BITS-1:0] alignedMantissaA,
    input  logic [`FP_EXT_BITS-1:0] alignedMantissaB,
    input  logic                    sticky,
    input  logic                    signA,
    input  logic                    signB,
    input  fpClass                  classA,
    input  fpClass                  classB,
    input  logic [`FP_EXP_BITS-1:0] exponentOut,
    output logic [`FP_EXT_BITS:0]   sumMantissa,
    output logic                    sumSign,
    output logic [31:0]             specialResult
);

    logic [`FP_EXT_BITS:0] extendedA;
    logic [`FP_EXT_BITS:0] extendedB;
    logic [`FP_EXT_BITS:0] borrow;
    logic [31:0]           packedA;
    logic [31:0]           packedB;

    assign extendedA = {1'b0, alignedMantissaA};
    assign extendedB = {1'b0, alignedMantissaB};
    // Truncated smaller operand is slightly too small, so take one more unit
    assign borrow = {{`FP_EXT_BITS{1'b0}}, sticky};

    always_comb
    begin
        sumSign = signA;
        if (signA == signB)
            sumMantissa = extendedA + extendedB;
        else if (extendedA >= extendedB)
            sumMantissa = extendedA - extendedB - borrow;
        else
        begin
            sumMantissa = extendedB - extendedA - borrow;
            sumSign = signB;
        end
        // Exact cancellation gives +0
        if (sumMantissa == '0)
            sumSign = 1'b0;
    end

    // Nonzero side of a zero operand sits unshifted at exponentOut
    assign packedA = {signA, (classA == fpNormal) ? exponentOut : `FP_EXP_BITS'd0,
                      alignedMantissaA[`FP_EXT_BITS-2 -: `FP_MAN_BITS]};
    assign packedB = {signB, (classB == fpNormal) ? exponentOut : `FP_EXP_BITS'd0,
                      alignedMantissaB[`FP_EXT_BITS-2 -: `FP_MAN_BITS]};

    always_comb
    begin
        if (classA == fpNan || classB == fpNan ||
            (classA == fpInfinity && classB == fpInfinity && signA != signB))
            specialResult = 32'h7fc0_0000;
        else if (classA == fpInfinity)
            specialResult = {signA, {`FP_EXP_BITS{1'b1}}, {`FP_MAN_BITS{1'b0}}};
        else if (classB == fpInfinity)
            specialResult = {signB, {`FP_EXP_BITS{1'b1}}, {`FP_MAN_BITS{1'b0}}};
        else if (classA == fpZero && classB == fpZero)
            specialResult = {signA & signB, 31'd0};
        else if (classA == fpZero)
            specialResult = packedB;
        else
            specialResult = packedA;
    end

endmodule

// ==== design/fpNormalize.sv ====
// Working mantissa and exponent, one-step shifts, nearest-even rounding and packing
`timescale 1ns/1ps
`include "fpAdder_defs.svh"

module fpNormalize
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    loadSum,
    input  logic                    loadSpecial,
    input  logic                    shiftRight,
    input  logic                    shiftLeft,
    input  logic                    doRound,
    input  logic [`FP_EXT_BITS:0]   sumMantissa,
    input  logic                    sumSign,
    input  logic [`FP_EXP_BITS-1:0] exponentIn,
    input  logic                    sticky,
    input  logic [31:0]             specialResult,
    output logic                    carryOut,
    output logic                    leadingOne,
    output logic                    exponentAtMin,
    output logic [31:0]             result
);

    localparam int ExpWidth = `FP_EXP_BITS + 2;
    localparam int GuardBits = `FP_EXT_BITS - `FP_MAN_BITS - 1;

    logic [`FP_EXT_BITS:0]   workMantissa;
    logic [ExpWidth-1:0]     workExponent;
    logic                    workSign;
    logic                    workSticky;
    logic [`FP_MAN_BITS:0]   keptMantissa;
    logic                    roundUp;
    logic [`FP_MAN_BITS+1:0] roundedMantissa;
    logic                    hiddenBit;
    logic [ExpWidth-1:0]     finalExponent;
    logic [31:0]             roundedResult;

    always_ff @(posedge clock)
    begin
        if (loadSum)
        begin
            workMantissa <= sumMantissa;
            workExponent <= {2'b00, exponentIn};
            workSign <= sumSign;
            workSticky <= sticky;
        end
        else if (shiftRight)
        begin
            workMantissa <= workMantissa >> 1;
            workExponent <= workExponent + 1'b1;
            workSticky <= workSticky | workMantissa[0];
        end
        else if (shiftLeft)
        begin
            workMantissa <= workMantissa << 1;
            workExponent <= workExponent - 1'b1;
        end
    end

    assign carryOut = workMantissa[`FP_EXT_BITS];
    assign leadingOne = workMantissa[`FP_EXT_BITS-1];
    assign exponentAtMin = (workExponent <= ExpWidth'(1));

    // Guard bit, then everything below it acts as sticky
    assign keptMantissa = workMantissa[`FP_EXT_BITS-1 -: `FP_MAN_BITS+1];
    assign roundUp = workMantissa[GuardBits-1] &
                     (|workMantissa[GuardBits-2:0] | workSticky | keptMantissa[0]);
    assign roundedMantissa = {1'b0, keptMantissa} + roundUp;

    assign hiddenBit = roundedMantissa[`FP_MAN_BITS+1] | roundedMantissa[`FP_MAN_BITS];
    assign finalExponent = workExponent + roundedMantissa[`FP_MAN_BITS+1];

    always_comb
    begin
        if (finalExponent >= ExpWidth'(2 * `FP_BIAS + 1))
            roundedResult = {workSign, {`FP_EXP_BITS{1'b1}}, {`FP_MAN_BITS{1'b0}}};
        else if (!hiddenBit)
            roundedResult = {workSign, {`FP_EXP_BITS{1'b0}}, roundedMantissa[`FP_MAN_BITS-1:0]};
        else
            roundedResult = {workSign, finalExponent[`FP_EXP_BITS-1:0],
                             roundedMantissa[`FP_MAN_BITS-1:0]};
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            result <= '0;
        else if (loadSpecial)
            result <= specialResult;
        else if (doRound)
            result <= roundedResult;
    end

endmodule

// ==== design/normShiftCounter.sv ====
// Bounded counter of normalization left shifts
`timescale 1ns/1ps
`include "fpAdder_defs.svh"

module normShiftCounter
(
    input  logic clock,
    input  logic reset,
    input  logic clear,
    input  logic step,
    output logic limitReached
);

    localparam int CountBits = $clog2(`FP_MAX_NORM_SHIFTS + 1);

    logic [CountBits-1:0] count;

    always_ff @(posedge clock)
    begin
        if (reset || clear)
            count <= '0;
        else if (step && !limitReached)
            count <= count + 1'b1;
    end

    assign limitReached = (count == CountBits'(`FP_MAX_NORM_SHIFTS));

endmodule

// ==== design/fpAddControl.sv ====
// Sequencing state machine of the floating-point adder
`timescale 1ns/1ps

module fpAddControl
    import fpAdderPkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic bypass,
    input  logic carryOut,
    input  logic leadingOne,
    input  logic exponentAtMin,
    input  logic limitReached,
    output logic loadOperands,
    output logic loadSum,
    output logic loadSpecial,
    output logic shiftRight,
    output logic shiftLeft,
    output logic doRound,
    output logic countClear,
    output logic countStep,
    output logic busy,
    output logic done
);

    addState state;
    addState nextState;
    logic    stopLeft;

    assign stopLeft = leadingOne | exponentAtMin | limitReached;

    always_ff @(posedge clock)
    begin
        if (reset)
            state <= stateIdle;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            stateIdle:
                if (start)
                    nextState = stateAlign;
            stateAlign:
                nextState = bypass ? stateFinish : stateAdd;
            stateAdd:
                if (carryOut)
                    nextState = stateNormRight;
                else if (!leadingOne)
                    nextState = stateNormLeft;
                else
                    nextState = stateRound;
            stateNormRight:
                nextState = stateRound;
            stateNormLeft:
                if (stopLeft)
                    nextState = stateRound;
            stateRound:
                nextState = stateFinish;
            default:
                nextState = stateIdle;
        endcase
    end

    assign loadOperands = (state == stateIdle) && start;
    assign loadSum = (state == stateAlign) && !bypass;
    assign loadSpecial = (state == stateAlign) && bypass;
    assign countClear = (state == stateAdd);
    assign shiftRight = (state == stateNormRight);
    assign shiftLeft = (state == stateNormLeft) && !stopLeft;
    assign countStep = shiftLeft;
    assign doRound = (state == stateRound);

    // Done ends the busy window
    assign busy = (state != stateIdle) && (state != stateFinish);
    assign done = (state == stateFinish);

endmodule

// ==== design/fpAdder.sv ====
// Top level of the multi-cycle single-precision adder and subtractor
`timescale 1ns/1ps
`include "fpAdder_defs.svh"

module fpAdder
    import fpAdderPkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic [31:0] operandA,
    input  logic [31:0] operandB,
    input  logic        subtract,
    output logic        busy,
    output logic        done,
    output logic [31:0] result
);

    logic                    signA;
    logic                    signB;
    logic [`FP_EXP_BITS-1:0] exponentA;
    logic [`FP_EXP_BITS-1:0] exponentB;
    logic [`FP_MAN_BITS-1:0] mantissaA;
    logic [`FP_MAN_BITS-1:0] mantissaB;
    fpClass                  classA;
    fpClass                  classB;
    logic [`FP_EXP_BITS-1:0] exponentOut;
    logic [`FP_EXT_BITS-1:0] alignedMantissaA;
    logic [`FP_EXT_BITS-1:0] alignedMantissaB;
    logic                    sticky;
    logic                    shiftOverflow;
    logic                    bypass;
    logic [`FP_EXT_BITS:0]   sumMantissa;
    logic                    sumSign;
    logic [31:0]             specialResult;
    logic                    carryOut;
    logic                    leadingOne;
    logic                    exponentAtMin;
    logic                    limitReached;
    logic                    loadOperands;
    logic                    loadSum;
    logic                    loadSpecial;
    logic                    shiftRight;
    logic                    shiftLeft;
    logic                    doRound;
    logic                    countClear;
    logic                    countStep;

    fpUnpack unpack (
        .clock(clock), .reset(reset), .load(loadOperands),
        .operandA(operandA), .operandB(operandB), .subtract(subtract),
        .signA(signA), .signB(signB), .exponentA(exponentA), .exponentB(exponentB),
        .mantissaA(mantissaA), .mantissaB(mantissaB), .classA(classA), .classB(classB)
    );

    fpAlign align (
        .exponentA(exponentA), .exponentB(exponentB),
        .mantissaA(mantissaA), .mantissaB(mantissaB), .classA(classA), .classB(classB),
        .exponentOut(exponentOut), .alignedMantissaA(alignedMantissaA),
        .alignedMantissaB(alignedMantissaB), .sticky(sticky),
        .shiftOverflow(shiftOverflow), .bypass(bypass)
    );

    // Bits lost in alignment borrow one unit in a long subtraction
    fpMantissaAdd mantissaAdd (
        .alignedMantissaA(alignedMantissaA), .alignedMantissaB(alignedMantissaB),
        .sticky(shiftOverflow), .signA(signA), .signB(signB),
        .classA(classA), .classB(classB), .exponentOut(exponentOut),
        .sumMantissa(sumMantissa), .sumSign(sumSign), .specialResult(specialResult)
    );

    fpNormalize normalize (
        .clock(clock), .reset(reset), .loadSum(loadSum), .loadSpecial(loadSpecial),
        .shiftRight(shiftRight), .shiftLeft(shiftLeft), .doRound(doRound),
        .sumMantissa(sumMantissa), .sumSign(sumSign), .exponentIn(exponentOut),
        .sticky(sticky), .specialResult(specialResult), .carryOut(carryOut),
        .leadingOne(leadingOne), .exponentAtMin(exponentAtMin), .result(result)
    );

    normShiftCounter shiftCounter (
        .clock(clock), .reset(reset), .clear(countClear), .step(countStep),
        .limitReached(limitReached)
    );

    fpAddControl control (
        .clock(clock), .reset(reset), .start(start), .bypass(bypass),
        .carryOut(carryOut), .leadingOne(leadingOne), .exponentAtMin(exponentAtMin),
        .limitReached(limitReached), .loadOperands(loadOperands), .loadSum(loadSum),
        .loadSpecial(loadSpecial), .shiftRight(shiftRight), .shiftLeft(shiftLeft),
        .doRound(doRound), .countClear(countClear), .countStep(countStep),
        .busy(busy), .done(done)
    );

endmodule

// ==== sim/fpAdder_assert.sv ====
// Bound concurrent assertions on the adder protocol and special-case results
`timescale 1ns/1ps

module fpAdder_assert
    import fpAdderPkg::*;
(
    input logic        clock,
    input logic        reset,
    input logic        start,
    input logic [31:0] operandA,
    input logic [31:0] operandB,
    input logic        subtract,
    input logic        busy,
    input logic        done,
    input logic [31:0] result,
    input addState     controlState
);

    int assertFailures = 0;

    logic        accepted;
    logic        pending;
    logic [31:0] capturedA;
    logic [31:0] capturedB;
    logic        capturedSub;
    logic [31:0] effectiveB;
    logic        nanOperand;
    logic        cancelOperands;
    logic        zeroOperandB;
    logic        resultNan;

    assign accepted = start && (controlState == stateIdle);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pending <= 1'b0;
            capturedA <= '0;
            capturedB <= '0;
            capturedSub <= 1'b0;
        end
        else if (accepted)
        begin
            pending <= 1'b1;
            capturedA <= operandA;
            capturedB <= operandB;
            capturedSub <= subtract;
        end
        else if (done)
            pending <= 1'b0;
    end

    // B as it enters the sum
    assign effectiveB = capturedB ^ {capturedSub, 31'd0};

    assign nanOperand = (&capturedA[30:23] && |capturedA[22:0]) ||
                        (&capturedB[30:23] && |capturedB[22:0]);
    assign cancelOperands = !(&capturedA[30:23]) &&
                            (effectiveB == {~capturedA[31], capturedA[30:0]});
    // A NaN or zero A does not come back unchanged
    assign zeroOperandB = (capturedB[30:0] == '0) && (capturedA[30:0] != '0) &&
                          !(&capturedA[30:23] && |capturedA[22:0]);
    assign resultNan = &result[30:23] && |result[22:0];

    resetIdle: assert property (@(posedge clock)
        reset |=> (controlState == stateIdle) && !busy && !done)
        else begin assertFailures++; $error("State not idle after reset"); end

    donePulse: assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else begin assertFailures++; $error("done held longer than one cycle"); end

    doneNotBusy: assert property (@(posedge clock) disable iff (reset) done |-> !busy)
        else begin assertFailures++; $error("busy high together with done"); end

    busyWhileRunning: assert property (@(posedge clock) disable iff (reset)
        pending && !done |-> busy)
        else begin assertFailures++; $error("busy low while an operation runs"); end

    doneAfterStart: assert property (@(posedge clock) disable iff (reset) done |-> pending)
        else begin assertFailures++; $error("done without an accepted start"); end

    nanResult: assert property (@(posedge clock) disable iff (reset)
        done && nanOperand |-> resultNan)
        else begin assertFailures++; $error("NaN operand gave a non-NaN result"); end

    cancelToZero: assert property (@(posedge clock) disable iff (reset)
        done && cancelOperands |-> result == 32'h0000_0000)
        else begin assertFailures++; $error("x plus -x did not give +0"); end

    zeroKeepsA: assert property (@(posedge clock) disable iff (reset)
        done && zeroOperandB |-> result == capturedA)
        else begin assertFailures++; $error("Zero operand B did not return operand A"); end

endmodule

// ==== sim/fpAdder_tb.sv ====
// Testbench of the single-precision adder with directed, special and random operands
`timescale 1ns/1ps

module fpAdder_tb;

    localparam int ClockPeriod = 40;
    localparam int MaxLatency = 40;
    localparam int DirectedOps = 27;
    localparam int RandomPairs = 20;
    localparam int OpCount = DirectedOps + 3 * RandomPairs;
    localparam int WatchdogTime = (OpCount * MaxLatency + 20) * ClockPeriod;

    logic        clock;
    logic        reset;
    logic        start;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic        subtract;
    logic        busy;
    logic        done;
    logic [31:0] result;

    int          testCount;
    int          failCount;
    logic [31:0] lfsrState;

    fpAdder UUT (
        .clock(clock), .reset(reset), .start(start), .operandA(operandA),
        .operandB(operandB), .subtract(subtract), .busy(busy), .done(done), .result(result)
    );

    bind fpAdder fpAdder_assert checks (
        .clock(clock), .reset(reset), .start(start), .operandA(operandA),
        .operandB(operandB), .subtract(subtract), .busy(busy), .done(done),
        .result(result), .controlState(control.state)
    );

    always #(ClockPeriod / 2) clock = ~clock;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] value);
        if (value[0])
            return (value >> 1) ^ 32'h8020_0003;
        return value >> 1;
    endfunction

    task automatic randomOperand(output logic [31:0] word);
        for (int i = 0; i < 32; i++)
        begin
            word[i] = lfsrState[0];
            lfsrState = nextLfsr(lfsrState);
        end
        // Keep the operand finite
        if (&word[30:23])
            word[30] = 1'b0;
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic executeOp(input logic [31:0] a, input logic [31:0] b, input logic sub,
                             output logic [31:0] value, output int cycles,
                             output logic finished);
        operandA = a;
        operandB = b;
        subtract = sub;
        start = 1'b1;
        @(posedge clock);
        #1 start = 1'b0;
        cycles = 0;
        while (!done && cycles < MaxLatency)
        begin
            @(negedge clock);
            cycles++;
        end
        finished = done;
        value = result;
        @(posedge clock);
        #1;
    endtask

    // Zero for expectedCycles leaves the latency unchecked
    task automatic checkOp(input string name, input logic [31:0] a, input logic [31:0] b,
                           input logic sub, input logic [31:0] expected,
                           input int expectedCycles);
        logic [31:0] value;
        int          cycles;
        logic        finished;
        logic        ok;
        executeOp(a, b, sub, value, cycles, finished);
        testCount++;
        ok = 1'b1;
        if (!finished)
        begin
            $display("Test %s: no done within %0d cycles of start", name, MaxLatency);
            ok = 1'b0;
        end
        else
        begin
            assert (value === expected)
            else
            begin
                $display("Mismatch in %s: expected %h, actual %h", name, expected, value);
                ok = 1'b0;
            end
            if (expectedCycles != 0)
                assert (cycles == expectedCycles)
                else
                begin
                    $display("Test %s: done came %0d cycles after start, not %0d",
                             name, cycles, expectedCycles);
                    ok = 1'b0;
                end
        end
        if (!ok)
            failCount++;
        $display("Test %s: %s", name, ok ? "ok" : "wrong");
    endtask

    initial
    begin
        #(WatchdogTime);
        $display("Watchdog expired after %0d ns with tests still running", WatchdogTime);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        int          cycles;
        logic        finished;
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        operandA = '0;
        operandB = '0;
        subtract = 1'b0;
        testCount = 0;
        failCount = 0;
        lfsrState = 32'd18;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;

        // Exact sums of small values
        checkOp("1 + 2", 32'h3f80_0000, 32'h4000_0000, 1'b0, 32'h4040_0000, 0);
        checkOp("3.5 - 1.25", 32'h4060_0000, 32'h3fa0_0000, 1'b1, 32'h4010_0000, 0);
        checkOp("-3 + 1", 32'hc040_0000, 32'h3f80_0000, 1'b0, 32'hc000_0000, 0);
        checkOp("-1.5 - 2.5", 32'hbfc0_0000, 32'h4020_0000, 1'b1, 32'hc080_0000, 0);
        checkOp("6 - 10", 32'h40c0_0000, 32'h4120_0000, 1'b1, 32'hc080_0000, 0);
        checkOp("100 + 28", 32'h42c8_0000, 32'h41e0_0000, 1'b0, 32'h4300_0000, 0);

        // Special operands bypass the arithmetic
        checkOp("NaN + 1", 32'h7fc0_0000, 32'h3f80_0000, 1'b0, 32'h7fc0_0000, 2);
        checkOp("1 - sNaN", 32'h3f80_0000, 32'h7f81_2345, 1'b1, 32'h7fc0_0000, 2);
        checkOp("inf + 1", 32'h7f80_0000, 32'h3f80_0000, 1'b0, 32'h7f80_0000, 2);
        checkOp("1 - inf", 32'h3f80_0000, 32'h7f80_0000, 1'b1, 32'hff80_0000, 2);
        checkOp("inf - inf", 32'h7f80_0000, 32'h7f80_0000, 1'b1, 32'h7fc0_0000, 2);
        checkOp("-inf + -inf", 32'hff80_0000, 32'hff80_0000, 1'b0, 32'hff80_0000, 2);
        checkOp("+0 + -0", 32'h0000_0000, 32'h8000_0000, 1'b0, 32'h0000_0000, 2);
        checkOp("-0 + -0", 32'h8000_0000, 32'h8000_0000, 1'b0, 32'h8000_0000, 2);
        checkOp("-0 - +0", 32'h8000_0000, 32'h0000_0000, 1'b1, 32'h8000_0000, 2);
        checkOp("0 - 2.5", 32'h0000_0000, 32'h4020_0000, 1'b1, 32'hc020_0000, 2);
        checkOp("-7 + 0", 32'hc0e0_0000, 32'h0000_0000, 1'b0, 32'hc0e0_0000, 2);

        // Cancellation and long left normalization
        checkOp("2.5 - 2.5", 32'h4020_0000, 32'h4020_0000, 1'b1, 32'h0000_0000, 0);
        checkOp("1 - (1 - 2^-23)", 32'h3f80_0000, 32'h3f7f_fffe, 1'b1, 32'h3400_0000, 0);

        // Round to nearest even
        checkOp("1 + 2^-24", 32'h3f80_0000, 32'h3380_0000, 1'b0, 32'h3f80_0000, 0);
        checkOp("1 + 3*2^-25", 32'h3f80_0000, 32'h33c0_0000, 1'b0, 32'h3f80_0001, 0);
        checkOp("(1 + 2^-23) + 2^-24", 32'h3f80_0001, 32'h3380_0000, 1'b0, 32'h3f80_0002, 0);
        checkOp("1 + 2^-40", 32'h3f80_0000, 32'h2b80_0000, 1'b0, 32'h3f80_0000, 0);
        checkOp("1 - 2^-40", 32'h3f80_0000, 32'h2b80_0000, 1'b1, 32'h3f80_0000, 0);

        // Subnormals and overflow
        checkOp("min subnormal x2", 32'h0000_0001, 32'h0000_0001, 1'b0, 32'h0000_0002, 0);
        checkOp("max subnormal + min", 32'h007f_ffff, 32'h0000_0001, 1'b0, 32'h0080_0000, 0);
        checkOp("max finite x2", 32'h7f7f_ffff, 32'h7f7f_ffff, 1'b0, 32'h7f80_0000, 0);

        // Random finite pairs
        for (int i = 0; i < RandomPairs; i++)
        begin
            randomOperand(a);
            randomOperand(b);
            executeOp(a, b, 1'b0, sum, cycles, finished);
            if (!finished)
            begin
                $display("Test random %0d a + b: no done within %0d cycles of start",
                         i, MaxLatency);
                failCount++;
            end
            checkOp($sformatf("random %0d b + a", i), b, a, 1'b0, sum, 0);
            checkOp($sformatf("random %0d a - a", i), a, a, 1'b1, 32'h0000_0000, 0);
        end

        $display("Tests run: %0d, with errors: %0d, assertion failures: %0d",
                 testCount, failCount, UUT.checks.assertFailures);
        if (failCount == 0 && UUT.checks.assertFailures == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/fpAdderPkg.sv
design/fpUnpack.sv
design/fpAlign.sv
design/fpMantissaAdd.sv
design/fpNormalize.sv
design/normShiftCounter.sv
design/fpAddControl.sv
design/fpAdder.sv
sim/fpAdder_assert.sv
sim/fpAdder_tb.sv

// ==== Makefile ====
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = fpAdder_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = All tests passed
FAIL_MSG  = Some tests failed

SOURCES = $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
